//--- cpu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_assert (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    imem_req_i,
    input  cpu_types_pkg::u32_t     imem_addr_i,
    input  logic [3:0]              wen_i,
    input  cpu_types_pkg::reg_idx_t wnum_i
);

    wen_whole: assert property (@(posedge clk) disable iff (!rst_n)
        wen_i == 4'h0 || wen_i == 4'hf)
        else $error("debug write enable %b is partial", wen_i);

    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wen_i != 4'h0 |-> wnum_i != 5'd0)
        else $error("debug port reports a write to r0");

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_i |-> imem_addr_i[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", imem_addr_i);

    // checked while reset is held
    no_req_in_reset: assert property (@(posedge clk)
        !rst_n |-> !imem_req_i)
        else $error("instruction request during reset");

endmodule

bind cpu_top cpu_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req_i  (imem_req_o),
    .imem_addr_i (imem_addr_o),
    .wen_i       (debug_wb_rf_wen_o),
    .wnum_i      (debug_wb_rf_wnum_o)
);

`default_nettype wire

//--- cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;
    import cpu_types_pkg::*;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        u32_t     inst;
    } fetch_decode_pass_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        alu_op_t  alu_op;
        br_kind_t br_kind;
        u32_t     op_a;
        u32_t     op_b;
        u32_t     cmp;      // rd value for beq/bne
        u32_t     target;
        logic     we;
        reg_idx_t rd;
    } decode_execute_pass_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        logic     we;
        reg_idx_t rd;
        u32_t     result;
    } execute_wb_pass_t;

    // result offered to decode
    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        u32_t     data;
    } forward_req_t;

endpackage

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
    parameter cpu_types_pkg::u32_t RESET_PC = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    imem_req_o,
    output cpu_types_pkg::u32_t     imem_addr_o,
    input  logic                    imem_valid_i,
    input  cpu_types_pkg::u32_t     imem_data_i,
    output cpu_types_pkg::u32_t     debug_wb_pc_o,
    output logic [3:0]              debug_wb_rf_wen_o,
    output cpu_types_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output cpu_types_pkg::u32_t     debug_wb_rf_wdata_o
);
    import cpu_types_pkg::*;
    import cpu_pipe_pkg::*;

    // passes
    fetch_decode_pass_t   pass_if;
    decode_execute_pass_t pass_id;

    logic br_taken;  // also the flush of decode
    u32_t br_target;
    forward_req_t ex_fwd, wb_fwd;

    reg_idx_t rj, rkd, rd;
    u32_t rj_data, rkd_data, rd_data;
    logic reg_we;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .rst_n,
        .br_taken_i  (br_taken),
        .br_target_i (br_target),
        .imem_req_o, .imem_addr_o,
        .imem_valid_i, .imem_data_i,
        .pass_o      (pass_if)
    );

    decode_stage u_decode (
        .clk, .rst_n,
        .flush_i    (br_taken),
        .pass_i     (pass_if),
        .rj_o       (rj),
        .rkd_o      (rkd),
        .rj_data_i  (rj_data),
        .rkd_data_i (rkd_data),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb_fwd),
        .pass_o     (pass_id)
    );

    reg_file u_regs (
        .clk, .rst_n,
        .rj_i       (rj),
        .rkd_i      (rkd),
        .rj_data_o  (rj_data),
        .rkd_data_o (rkd_data),
        .we_i       (reg_we),
        .rd_i       (rd),
        .rd_data_i  (rd_data)
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .pass_i      (pass_id),
        .br_taken_o  (br_taken),
        .br_target_o (br_target),
        .ex_fwd_o    (ex_fwd),
        .wb_fwd_o    (wb_fwd),
        .reg_we_o    (reg_we),
        .reg_idx_o   (rd),
        .reg_data_o  (rd_data),
        .debug_wb_pc_o, .debug_wb_rf_wen_o,
        .debug_wb_rf_wnum_o, .debug_wb_rf_wdata_o
    );

endmodule

`default_nettype wire

//--- cpu_trace.txt
# I <instruction hex>, stored at word addresses 0, 4, 8 and on
# W <test> <pc hex> <register hex> <data hex>, expected writes in program order
I 02801401
I 142468A2
I 00100823
I 00110C24
I 00150C85
I 00148CA6
I 00158CA0
I 00100407
I 5C000827
I 58000C27
I 02800408
I 02800808
I 02BFFC09
I 50000C00
I 02800C08
I 02801008
I 0280092A
I 50000000
W alu_imm 00000000 01 00000005
W alu_imm 00000004 02 12345000
W alu_fwd 00000008 03 12345005
W alu_fwd 0000000c 04 edcbb000
W alu_fwd 00000010 05 fffff005
W alu_fwd 00000014 06 12345005
W r0_zero 0000001c 07 00000005
W branch 00000030 09 ffffffff
W branch 00000040 0a 00000001

//--- cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    typedef logic [31:0] u32_t;     // data or address word
    typedef logic [4:0]  reg_idx_t;

    // major opcode slices of the supported encodings
    typedef logic [16:0] op_3r_t;     // inst[31:15]
    typedef logic [9:0]  op_2ri12_t;  // inst[31:22]
    typedef logic [6:0]  op_1ri20_t;  // inst[31:25]
    typedef logic [5:0]  op_br_t;     // inst[31:26]

    localparam op_3r_t    OP_ADD_W   = 17'h00020;
    localparam op_3r_t    OP_SUB_W   = 17'h00022;
    localparam op_3r_t    OP_AND     = 17'h00029;
    localparam op_3r_t    OP_OR      = 17'h0002a;
    localparam op_3r_t    OP_XOR     = 17'h0002b;
    localparam op_2ri12_t OP_ADDI_W  = 10'h00a;
    localparam op_1ri20_t OP_LU12I_W = 7'h0a;
    localparam op_br_t    OP_BEQ     = 6'h16;
    localparam op_br_t    OP_BNE     = 6'h17;
    localparam op_br_t    OP_B       = 6'h14;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B  // pass_b for lu12i.w
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE, BR_EQ, BR_NE, BR_ALWAYS
    } br_kind_t;

endpackage

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush_i,
    input  cpu_pipe_pkg::fetch_decode_pass_t   pass_i,
    output cpu_types_pkg::reg_idx_t            rj_o,
    output cpu_types_pkg::reg_idx_t            rkd_o,
    input  cpu_types_pkg::u32_t                rj_data_i,
    input  cpu_types_pkg::u32_t                rkd_data_i,
    input  cpu_pipe_pkg::forward_req_t         ex_fwd_i,
    input  cpu_pipe_pkg::forward_req_t         wb_fwd_i,
    output cpu_pipe_pkg::decode_execute_pass_t pass_o
);
    import cpu_types_pkg::*;
    import cpu_pipe_pkg::*;

    // execute wins over writeback, writeback over the register file
    function automatic u32_t fwd_sel(input reg_idx_t idx, input u32_t rf_val);
        if (idx == '0)
            return rf_val;
        if (ex_fwd_i.valid && ex_fwd_i.idx == idx)
            return ex_fwd_i.data;
        if (wb_fwd_i.valid && wb_fwd_i.idx == idx)
            return wb_fwd_i.data;
        return rf_val;
    endfunction

    u32_t     inst;
    reg_idx_t rd;
    logic     d_known, d_we, d_use_imm;
    alu_op_t  d_alu;
    br_kind_t d_br;
    u32_t     d_imm, d_off, rj_val, rkd_val;
    decode_execute_pass_t de_nxt;

    assign inst = pass_i.inst;
    assign rd   = inst[4:0];

    // ============================================================
    // instruction decode
    // ============================================================
    always_comb begin
        d_known   = 1'b1;
        d_we      = 1'b1;
        d_use_imm = 1'b0;
        d_alu     = ALU_ADD;
        d_br      = BR_NONE;
        d_imm     = {{20{inst[21]}}, inst[21:10]};               // si12
        d_off     = {{14{inst[25]}}, inst[25:10], 2'b00};         // offs16
        if (inst[31:22] == OP_ADDI_W) begin
            d_use_imm = 1'b1;
        end else if (inst[31:25] == OP_LU12I_W) begin
            d_alu     = ALU_PASS_B;
            d_use_imm = 1'b1;
            d_imm     = {inst[24:5], 12'h000};
        end else if (inst[31:26] == OP_BEQ || inst[31:26] == OP_BNE) begin
            d_we = 1'b0;
            d_br = (inst[31:26] == OP_BEQ) ? BR_EQ : BR_NE;
        end else if (inst[31:26] == OP_B) begin
            d_we  = 1'b0;
            d_br  = BR_ALWAYS;
            d_off = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};  // offs26
        end else begin
            case (inst[31:15])
                OP_ADD_W: d_alu = ALU_ADD;
                OP_SUB_W: d_alu = ALU_SUB;
                OP_AND:   d_alu = ALU_AND;
                OP_OR:    d_alu = ALU_OR;
                OP_XOR:   d_alu = ALU_XOR;
                default:  d_known = 1'b0;  // becomes a bubble
            endcase
        end
    end

    assign rj_o    = inst[9:5];
    assign rkd_o   = (d_br == BR_EQ || d_br == BR_NE) ? rd : inst[14:10];

    always_comb begin
        rj_val  = fwd_sel(rj_o, rj_data_i);
        rkd_val = fwd_sel(rkd_o, rkd_data_i);
    end

    always_comb begin
        de_nxt.valid   = pass_i.valid & d_known & ~flush_i;
        de_nxt.pc      = pass_i.pc;
        de_nxt.alu_op  = d_alu;
        de_nxt.br_kind = d_br;
        de_nxt.op_a    = rj_val;
        de_nxt.op_b    = d_use_imm ? d_imm : rkd_val;
        de_nxt.cmp     = rkd_val;
        de_nxt.target  = pass_i.pc + d_off;
        de_nxt.we      = d_we & (rd != '0);  // r0 never written
        de_nxt.rd      = rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pass_o <= '0;
        else
            pass_o <= de_nxt;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  cpu_pipe_pkg::decode_execute_pass_t pass_i,
    output logic                               br_taken_o,
    output cpu_types_pkg::u32_t                br_target_o,
    output cpu_pipe_pkg::forward_req_t         ex_fwd_o,
    output cpu_pipe_pkg::forward_req_t         wb_fwd_o,
    output logic                               reg_we_o,
    output cpu_types_pkg::reg_idx_t            reg_idx_o,
    output cpu_types_pkg::u32_t                reg_data_o,
    output cpu_types_pkg::u32_t                debug_wb_pc_o,
    output logic [3:0]                         debug_wb_rf_wen_o,
    output cpu_types_pkg::reg_idx_t            debug_wb_rf_wnum_o,
    output cpu_types_pkg::u32_t                debug_wb_rf_wdata_o
);
    import cpu_types_pkg::*;
    import cpu_pipe_pkg::*;

    u32_t alu_res;
    logic br_cond;
    execute_wb_pass_t wb_q;

    // ============================================================
    // ALU and branch
    // ============================================================
    always_comb begin
        case (pass_i.alu_op)
            ALU_ADD: alu_res = pass_i.op_a + pass_i.op_b;
            ALU_SUB: alu_res = pass_i.op_a - pass_i.op_b;
            ALU_AND: alu_res = pass_i.op_a & pass_i.op_b;
            ALU_OR:  alu_res = pass_i.op_a | pass_i.op_b;
            ALU_XOR: alu_res = pass_i.op_a ^ pass_i.op_b;
            default: alu_res = pass_i.op_b;  // lu12i.w
        endcase
    end

    always_comb begin
        case (pass_i.br_kind)
            BR_EQ:     br_cond = (pass_i.op_a == pass_i.cmp);
            BR_NE:     br_cond = (pass_i.op_a != pass_i.cmp);
            BR_ALWAYS: br_cond = 1'b1;
            default:   br_cond = 1'b0;
        endcase
    end

    // no predictor, so every taken branch redirects
    assign br_taken_o  = pass_i.valid & br_cond;
    assign br_target_o = pass_i.target;

    assign ex_fwd_o = '{pass_i.valid & pass_i.we, pass_i.rd, alu_res};

    // ============================================================
    // writeback register
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_q <= '0;
        else
            wb_q <= '{pass_i.valid, pass_i.pc, pass_i.valid & pass_i.we, pass_i.rd, alu_res};
    end

    assign reg_we_o   = wb_q.valid & wb_q.we;
    assign reg_idx_o  = wb_q.rd;
    assign reg_data_o = wb_q.result;
    assign wb_fwd_o   = '{reg_we_o, wb_q.rd, wb_q.result};

    assign debug_wb_pc_o       = wb_q.pc;
    assign debug_wb_rf_wen_o   = {4{reg_we_o}};  // all byte lanes
    assign debug_wb_rf_wnum_o  = wb_q.rd;
    assign debug_wb_rf_wdata_o = wb_q.result;

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter cpu_types_pkg::u32_t RESET_PC = 32'h0
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             br_taken_i,
    input  cpu_types_pkg::u32_t              br_target_i,
    output logic                             imem_req_o,
    output cpu_types_pkg::u32_t              imem_addr_o,
    input  logic                             imem_valid_i,
    input  cpu_types_pkg::u32_t              imem_data_i,
    output cpu_pipe_pkg::fetch_decode_pass_t pass_o
);
    import cpu_types_pkg::*;

    logic run_q;     // out of reset, requesting
    logic live_q;    // outstanding request not flushed
    u32_t pc_q;      // restart pc after reset or redirect
    u32_t out_pc_q;  // pc of outstanding request

    // next address depends on what comes back this cycle
    always_comb begin
        if (!live_q) begin
            imem_addr_o = pc_q;
        end else if (imem_valid_i) begin
            imem_addr_o = out_pc_q + 32'd4;
        end else begin
            imem_addr_o = out_pc_q;  // word lost, ask again
        end
    end

    assign imem_req_o = run_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            live_q <= 1'b0;
            pc_q   <= RESET_PC;
        end else begin
            run_q  <= 1'b1;
            live_q <= imem_req_o & ~br_taken_i;  // kill the request of this cycle
            if (br_taken_i)
                pc_q <= br_target_i;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req_o)
            out_pc_q <= imem_addr_o;
    end

    assign pass_o = '{live_q & imem_valid_i, out_pc_q, imem_data_i};

endmodule

`default_nettype wire

//--- project.f
cpu_types_pkg.sv
cpu_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
cpu_top.sv
cpu_assert.sv
tb_cpu.sv

//--- reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_types_pkg::reg_idx_t rj_i,
    input  cpu_types_pkg::reg_idx_t rkd_i,
    output cpu_types_pkg::u32_t     rj_data_o,
    output cpu_types_pkg::u32_t     rkd_data_o,
    input  logic                    we_i,
    input  cpu_types_pkg::reg_idx_t rd_i,
    input  cpu_types_pkg::u32_t     rd_data_i
);
    import cpu_types_pkg::*;

    u32_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && rd_i != '0) begin  // r0 stays zero
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rj_data_o  = regs[rj_i];
    assign rkd_data_o = regs[rkd_i];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu -f project.f -o sim_cpu \
    && ./obj_dir/sim_cpu > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Everything OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
    import cpu_types_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int WAIT_LIMIT  = 200;  // cycles per expected write
    localparam int IDLE_CYCLES = 50;

    logic       clk;
    logic       rst_n      = 1'b1;
    logic       imem_req;
    u32_t       imem_addr;
    logic       imem_valid = 1'b0;
    u32_t       imem_data  = '0;
    u32_t       debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    u32_t       debug_wb_rf_wdata;

    u32_t       imem [MEM_WORDS];
    bit         drop_pat [1024];
    logic [9:0] req_cnt    = '0;
    logic       drop_words;

    string      exp_test [$];
    u32_t       exp_pc [$];
    reg_idx_t   exp_idx [$];
    u32_t       exp_data [$];

    int         errors;
    int         tests_run;
    int         tests_failed;

    cpu_top #(.RESET_PC(32'h0)) DUT (
        .clk, .rst_n,
        .imem_req_o          (imem_req),
        .imem_addr_o         (imem_addr),
        .imem_valid_i        (imem_valid),
        .imem_data_i         (imem_data),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ============================================================
    // instruction memory, answers one cycle after the request
    // ============================================================
    always @(posedge clk) begin
        if (imem_req) begin
            imem_valid <= !(drop_words && drop_pat[req_cnt]);
            imem_data  <= imem[imem_addr[9:2]];
            req_cnt    <= req_cnt + 10'd1;
        end else begin
            imem_valid <= 1'b0;
        end
    end

    task automatic load_trace();
        int    fd;
        string line;
        string tag;
        string name;
        u32_t  a;
        u32_t  b;
        u32_t  c;
        int    n_words;
        n_words = 0;
        fd = $fopen("cpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            if (line[0] == "I") begin
                void'($sscanf(line, "%s %h", tag, a));
                imem[n_words] = a;
                n_words++;
            end else if (line[0] == "W") begin
                void'($sscanf(line, "%s %s %h %h %h", tag, name, a, b, c));
                exp_test.push_back(name);
                exp_pc.push_back(a);
                exp_idx.push_back(b[4:0]);
                exp_data.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic check_word(input string test, input string field,
                              input u32_t exp, input u32_t act);
        if (exp !== act) begin
            $display("ERR %s %s expected %h actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string test, input string field,
                             input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("ERR %s %s expected r%0d actual r%0d", test, field, exp, act);
            errors++;
        end
    endtask

    // sampled on the falling edge, each write lasts one cycle
    task automatic wait_write(output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = (debug_wb_rf_wen != 4'h0);
            n++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s", name);
            tests_failed++;
        end
    endtask

    task automatic check_writes(input logic grouped);
        logic  seen;
        string name;
        int    errors_before;
        int    i;
        name = grouped ? exp_test[0] : "random_valid";
        errors_before = errors;
        for (i = 0; i < exp_pc.size(); i++) begin
            if (grouped && exp_test[i] != name) begin
                finish_test(name, errors_before);
                name = exp_test[i];
                errors_before = errors;
            end
            wait_write(seen);
            if (!seen) begin
                $display("test %s: no register write arrived within %0d cycles",
                         name, WAIT_LIMIT);
                errors++;
                break;
            end
            check_word(name, "pc", exp_pc[i], debug_wb_pc);
            check_idx(name, "rd", exp_idx[i], debug_wb_rf_wnum);
            check_word(name, "data", exp_data[i], debug_wb_rf_wdata);
        end
        if (!grouped) begin
            for (i = 0; i < IDLE_CYCLES; i++) begin  // parked on the self-loop b
                @(negedge clk);
                if (debug_wb_rf_wen != 4'h0) begin
                    $display("test %s: register write seen after the final self-loop", name);
                    errors++;
                    break;
                end
            end
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        int i;
        void'($urandom(23673));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        drop_words   = 1'b0;
        rst_n <= 1'b0;
        for (i = 0; i < 1024; i++)
            drop_pat[i] = ($urandom() % 4 == 0);  // about one word in four
        for (i = 0; i < MEM_WORDS; i++)
            imem[i] = ~u32_t'(i * 4);
        load_trace();
        if (exp_pc.size() == 0) begin
            $display("the trace holds no expected register writes");
            errors++;
        end else begin
            apply_reset();
            check_writes(1'b1);
            drop_words = 1'b1;
            apply_reset();
            check_writes(1'b0);
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
